/* design/sched_pkg.sv */
package sched_pkg;

    // Sampling window, scaled down for short simulations
    localparam int WINDOW_CYCLES = 64;
    localparam int TIMER_W = $clog2(WINDOW_CYCLES);

    // Wide enough for a window of any practical length
    localparam int COUNT_W = 16;

    // ROB vote needs a count strictly above this
    localparam int ROB_FULL_THRESHOLD = 42;

    // Votes that force a migration on their own
    localparam int MIN_VOTES = 3;

    // One cycle of event strobes from a single core
    typedef struct packed {
        logic mult;
        logic mem_op;
        logic flush;
        logic alu_op;
        logic rob_full;
    } core_events_t;

    // Per-window totals of one core, same field order as the strobes
    typedef struct packed {
        logic [COUNT_W-1:0] mult;
        logic [COUNT_W-1:0] mem_op;
        logic [COUNT_W-1:0] flush;
        logic [COUNT_W-1:0] alu_op;
        logic [COUNT_W-1:0] rob_full;
    } event_counts_t;

    typedef struct packed {
        logic mult_vote;
        logic mem_vote;
        logic flush_vote;
        logic rob_vote;
        logic alu_vote;
    } vote_t;

    typedef enum logic {
        CORE_OOO,
        CORE_PPL
    } core_sel_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_DRAIN,
        ST_SWAP
    } ctrl_state_e;

    typedef struct packed {
        core_sel_e target;
    } swap_req_t;

endpackage

/* design/perf_event_sampler.sv */
`timescale 1ns/1ps

module perf_event_sampler (
    input  logic                     clk,
    input  logic                     rst,
    input  sched_pkg::core_events_t  events,
    input  logic                     window_end,
    output sched_pkg::event_counts_t snapshot
);

    sched_pkg::event_counts_t live;
    sched_pkg::event_counts_t total;

    function automatic logic [sched_pkg::COUNT_W-1:0] bump(
        input logic [sched_pkg::COUNT_W-1:0] cnt,
        input logic                          strobe
    );
        logic [sched_pkg::COUNT_W-1:0] inc;
        inc = {{(sched_pkg::COUNT_W-1){1'b0}}, strobe};
        return cnt + inc;
    endfunction

    // Live totals including this cycle's strobes
    always_comb begin
        total.mult     = bump(live.mult, events.mult);
        total.mem_op   = bump(live.mem_op, events.mem_op);
        total.flush    = bump(live.flush, events.flush);
        total.alu_op   = bump(live.alu_op, events.alu_op);
        total.rob_full = bump(live.rob_full, events.rob_full);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live     <= '0;
            snapshot <= '0;
        end else if (window_end) begin
            // Last cycle of the window still counts
            snapshot <= total;
            live     <= '0;
        end else begin
            live <= total;
        end
    end

    // At most one event per cycle, so a window can never exceed its length
    a_live_bounded: assert property (
        @(posedge clk) disable iff (rst)
        (live.mult     <= sched_pkg::COUNT_W'(sched_pkg::WINDOW_CYCLES)) &&
        (live.mem_op   <= sched_pkg::COUNT_W'(sched_pkg::WINDOW_CYCLES)) &&
        (live.flush    <= sched_pkg::COUNT_W'(sched_pkg::WINDOW_CYCLES)) &&
        (live.alu_op   <= sched_pkg::COUNT_W'(sched_pkg::WINDOW_CYCLES)) &&
        (live.rob_full <= sched_pkg::COUNT_W'(sched_pkg::WINDOW_CYCLES))
    ) else $error("perf_event_sampler: live count above window length");

endmodule

/* design/migration_vote.sv */
`timescale 1ns/1ps

module migration_vote (
    input  sched_pkg::event_counts_t ooo_snapshot,
    input  sched_pkg::event_counts_t ppl_snapshot,
    output sched_pkg::vote_t         votes,
    output logic                     migrate
);

    localparam logic [sched_pkg::COUNT_W-1:0] ROB_LIMIT =
        sched_pkg::COUNT_W'(sched_pkg::ROB_FULL_THRESHOLD);
    localparam logic [2:0] VOTE_LIMIT = 3'(sched_pkg::MIN_VOTES);

    logic [2:0] vote_count;
    logic       majority;
    logic       rob_alu_pair;

    // Each vote leans toward leaving the ooo core
    always_comb begin
        votes.mult_vote  = ooo_snapshot.mult < ppl_snapshot.mult;
        votes.mem_vote   = ooo_snapshot.mem_op > ppl_snapshot.mem_op;
        votes.flush_vote = ooo_snapshot.flush > ppl_snapshot.flush;
        votes.rob_vote   = ooo_snapshot.rob_full > ROB_LIMIT;
        votes.alu_vote   = ooo_snapshot.alu_op < ppl_snapshot.alu_op;
    end

    always_comb begin
        vote_count = 3'd0;
        vote_count = vote_count + {2'b00, votes.mult_vote};
        vote_count = vote_count + {2'b00, votes.mem_vote};
        vote_count = vote_count + {2'b00, votes.flush_vote};
        vote_count = vote_count + {2'b00, votes.rob_vote};
        vote_count = vote_count + {2'b00, votes.alu_vote};
    end

    assign majority = vote_count >= VOTE_LIMIT;

    // Saturated ROB with little ALU work is enough on its own
    assign rob_alu_pair = votes.rob_vote && votes.alu_vote;

    assign migrate = majority || rob_alu_pair;

endmodule

/* design/migration_controller.sv */
`timescale 1ns/1ps

module migration_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  migrate,
    input  logic                  rob_empty,
    input  logic                  swap_ready,
    output logic                  window_end,
    output logic                  draining,
    output logic                  swap_valid,
    output sched_pkg::swap_req_t  swap_req,
    output sched_pkg::core_sel_e  active_core
);

    localparam logic [sched_pkg::TIMER_W-1:0] LAST_CYCLE =
        sched_pkg::TIMER_W'(sched_pkg::WINDOW_CYCLES - 1);

    logic [sched_pkg::TIMER_W-1:0] timer;
    logic                          decide;
    sched_pkg::ctrl_state_e        state;
    sched_pkg::ctrl_state_e        state_next;

    // Window timer
    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
        end else if (window_end) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign window_end = timer == LAST_CYCLE;

    // Snapshot and vote are valid one cycle after window end
    always_ff @(posedge clk) begin
        if (rst) begin
            decide <= 1'b0;
        end else begin
            decide <= window_end;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            sched_pkg::ST_RUN: begin
                // Decisions taken during a drain or swap are dropped
                if (decide && migrate) begin
                    state_next = sched_pkg::ST_DRAIN;
                end
            end
            sched_pkg::ST_DRAIN: begin
                if (rob_empty) begin
                    state_next = sched_pkg::ST_SWAP;
                end
            end
            sched_pkg::ST_SWAP: begin
                if (swap_ready) begin
                    state_next = sched_pkg::ST_RUN;
                end
            end
            default: state_next = sched_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= sched_pkg::ST_RUN;
            active_core <= sched_pkg::CORE_OOO;
        end else begin
            state <= state_next;
            if (swap_valid && swap_ready) begin
                active_core <= (active_core == sched_pkg::CORE_OOO) ?
                               sched_pkg::CORE_PPL : sched_pkg::CORE_OOO;
            end
        end
    end

    assign draining   = state == sched_pkg::ST_DRAIN;
    assign swap_valid = state == sched_pkg::ST_SWAP;

    // Target is always the idle core, so it only moves at the transfer
    assign swap_req.target = (active_core == sched_pkg::CORE_OOO) ?
                             sched_pkg::CORE_PPL : sched_pkg::CORE_OOO;

    a_swap_hold: assert property (
        @(posedge clk) disable iff (rst)
        (swap_valid && !swap_ready) |=> (swap_valid && $stable(swap_req))
    ) else $error("migration_controller: swap request dropped or changed before ready");

    // A swap request only follows a drain that saw an empty ROB
    a_swap_after_drain: assert property (
        @(posedge clk) disable iff (rst)
        $rose(swap_valid) |-> $past(draining && rob_empty)
    ) else $error("migration_controller: swap_valid rose without a drained ROB");

endmodule

/* design/hybrid_scheduler.sv */
`timescale 1ns/1ps

module hybrid_scheduler (
    input  logic                    clk,
    input  logic                    rst,

    // Per-cycle event strobes from both cores
    input  sched_pkg::core_events_t ooo_events,
    input  sched_pkg::core_events_t ppl_events,

    input  logic                    rob_empty,
    input  logic                    swap_ready,

    // Swap request to the core-switch logic
    output logic                    swap_valid,
    output sched_pkg::swap_req_t    swap_req,
    output sched_pkg::core_sel_e    active_core,
    output logic                    draining,

    // Exported for observation only
    output sched_pkg::vote_t        votes
);

    logic                     window_end;
    logic                     migrate;
    sched_pkg::event_counts_t ooo_snapshot;
    sched_pkg::event_counts_t ppl_snapshot;

    perf_event_sampler i_ooo_sampler (
        .clk        (clk),
        .rst        (rst),
        .events     (ooo_events),
        .window_end (window_end),
        .snapshot   (ooo_snapshot)
    );

    perf_event_sampler i_ppl_sampler (
        .clk        (clk),
        .rst        (rst),
        .events     (ppl_events),
        .window_end (window_end),
        .snapshot   (ppl_snapshot)
    );

    migration_vote i_vote (
        .ooo_snapshot (ooo_snapshot),
        .ppl_snapshot (ppl_snapshot),
        .votes        (votes),
        .migrate      (migrate)
    );

    migration_controller i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .migrate     (migrate),
        .rob_empty   (rob_empty),
        .swap_ready  (swap_ready),
        .window_end  (window_end),
        .draining    (draining),
        .swap_valid  (swap_valid),
        .swap_req    (swap_req),
        .active_core (active_core)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released just after the eighth rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/tb_hybrid_scheduler.sv */
`timescale 1ns/1ps

module tb_hybrid_scheduler;

    localparam int TIMEOUT = 4 * sched_pkg::WINDOW_CYCLES;
    localparam int MAX_LINES = 32;

    logic                     clk;
    logic                     rst;
    sched_pkg::core_events_t  ooo_events;
    sched_pkg::core_events_t  ppl_events;
    logic                     rob_empty;
    logic                     swap_ready;
    logic                     swap_valid;
    sched_pkg::swap_req_t     swap_req;
    sched_pkg::core_sel_e     active_core;
    logic                     draining;
    sched_pkg::vote_t         votes;

    // Field order 0..4 is mult, mem_op, flush, alu_op, rob_full
    int   ooo_cnt [MAX_LINES][5];
    int   ppl_cnt [MAX_LINES][5];
    int   drain_delay [MAX_LINES];
    int   ready_delay [MAX_LINES];
    logic file_flag [MAX_LINES];
    int   num_lines;

    int value_errors;
    int data_errors;
    int timeouts;

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    hybrid_scheduler i_hybrid_scheduler (
        .clk         (clk),
        .rst         (rst),
        .ooo_events  (ooo_events),
        .ppl_events  (ppl_events),
        .rob_empty   (rob_empty),
        .swap_ready  (swap_ready),
        .swap_valid  (swap_valid),
        .swap_req    (swap_req),
        .active_core (active_core),
        .draining    (draining),
        .votes       (votes)
    );

    function automatic sched_pkg::vote_t predict_votes(input int idx);
        sched_pkg::vote_t v;
        v.mult_vote  = ooo_cnt[idx][0] < ppl_cnt[idx][0];
        v.mem_vote   = ooo_cnt[idx][1] > ppl_cnt[idx][1];
        v.flush_vote = ooo_cnt[idx][2] > ppl_cnt[idx][2];
        v.rob_vote   = ooo_cnt[idx][4] > sched_pkg::ROB_FULL_THRESHOLD;
        v.alu_vote   = ooo_cnt[idx][3] < ppl_cnt[idx][3];
        return v;
    endfunction

    function automatic logic predict_migrate(input sched_pkg::vote_t v);
        int n;
        n = int'(v.mult_vote) + int'(v.mem_vote) + int'(v.flush_vote) +
            int'(v.rob_vote) + int'(v.alu_vote);
        return (n >= sched_pkg::MIN_VOTES) || (v.rob_vote && v.alu_vote);
    endfunction

    // An event with count n strobes in the first n cycles of its window
    function automatic sched_pkg::core_events_t strobes_at(
        input int idx,
        input bit use_ppl,
        input int pos
    );
        sched_pkg::core_events_t ev;
        int c [5];
        int k;
        for (k = 0; k < 5; k++) begin
            c[k] = use_ppl ? ppl_cnt[idx][k] : ooo_cnt[idx][k];
        end
        ev.mult     = pos < c[0];
        ev.mem_op   = pos < c[1];
        ev.flush    = pos < c[2];
        ev.alu_op   = pos < c[3];
        ev.rob_full = pos < c[4];
        return ev;
    endfunction

    function automatic void compare_flag(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            value_errors++;
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endfunction

    function automatic void compare_core(
        input string                name,
        input sched_pkg::core_sel_e exp,
        input sched_pkg::core_sel_e act
    );
        assert (act === exp) else begin
            value_errors++;
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        end
    endfunction

    function automatic void compare_votes(
        input int               line_no,
        input sched_pkg::vote_t exp,
        input sched_pkg::vote_t act
    );
        assert (act === exp) else begin
            value_errors++;
            $display("ERROR votes (line %0d): expected 0x%0h, got 0x%0h", line_no, exp, act);
        end
    endfunction

    task automatic load_scenarios();
        int    fd;
        int    rc;
        int    n;
        int    k;
        int    v [13];
        string line;
        logic  exp_flag;
        num_lines = 0;
        fd = $fopen("testbench/sched_input.txt", "r");
        if (fd == 0) begin
            data_errors++;
            $display("Could not open the scenario file testbench/sched_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc != 0 && line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                            v[7], v[8], v[9], v[10], v[11], v[12]);
                if (n == 13 && num_lines < MAX_LINES) begin
                    for (k = 0; k < 5; k++) begin
                        ooo_cnt[num_lines][k] = v[k];
                        ppl_cnt[num_lines][k] = v[k + 5];
                    end
                    drain_delay[num_lines] = v[10];
                    ready_delay[num_lines] = v[11];
                    file_flag[num_lines]   = v[12] != 0;
                    exp_flag = predict_migrate(predict_votes(num_lines));
                    assert (file_flag[num_lines] == exp_flag) else begin
                        data_errors++;
                        $display("Bad data line %0d: migrate flag %0d does not follow from the counts",
                                 num_lines, v[12]);
                    end
                    num_lines++;
                end else if (n > 0) begin
                    data_errors++;
                    $display("Bad data line after scenario %0d: cannot read 13 values", num_lines);
                end
            end
        end
        $fclose(fd);
    endtask

    // One extra quiet window after the last scenario
    task automatic drive_windows();
        int w;
        int pos;
        for (w = 0; w <= num_lines; w++) begin
            for (pos = 0; pos < sched_pkg::WINDOW_CYCLES; pos++) begin
                if (w < num_lines) begin
                    ooo_events = strobes_at(w, 1'b0, pos);
                    ppl_events = strobes_at(w, 1'b1, pos);
                end else begin
                    ooo_events = '0;
                    ppl_events = '0;
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic audit_votes();
        int               w;
        int               g;
        sched_pkg::vote_t exp_votes;
        g = 0;
        for (w = 0; w < num_lines; w++) begin
            while (g < (w + 1) * sched_pkg::WINDOW_CYCLES) begin
                @(negedge clk);
                g++;
            end
            exp_votes = predict_votes(w);
            compare_votes(w, exp_votes, votes);
        end
    endtask

    task automatic serve_swaps();
        int                   w;
        int                   g;
        int                   dcyc;
        int                   guard;
        int                   drained;
        int                   held;
        sched_pkg::core_sel_e exp_core;
        sched_pkg::core_sel_e other_core;
        g = 0;
        exp_core = sched_pkg::CORE_OOO;
        for (w = 0; w < num_lines; w++) begin
            dcyc = (w + 1) * sched_pkg::WINDOW_CYCLES;
            // Decision fell inside the previous drain or swap
            if (g > dcyc) begin
                continue;
            end
            while (g < dcyc) begin
                compare_flag("draining", 1'b0, draining);
                compare_flag("swap_valid", 1'b0, swap_valid);
                compare_core("active_core", exp_core, active_core);
                @(negedge clk);
                g++;
            end
            compare_flag("draining", 1'b0, draining);
            compare_flag("swap_valid", 1'b0, swap_valid);
            if (!predict_migrate(predict_votes(w))) begin
                continue;
            end
            other_core = (exp_core == sched_pkg::CORE_OOO) ?
                         sched_pkg::CORE_PPL : sched_pkg::CORE_OOO;
            @(negedge clk);
            g++;
            // Two cycles after window_end
            compare_flag("draining", 1'b1, draining);
            drained = 0;
            guard = 0;
            while (!swap_valid && guard < TIMEOUT) begin
                rob_empty = drained >= drain_delay[w];
                compare_flag("draining", 1'b1, draining);
                drained++;
                guard++;
                @(negedge clk);
                g++;
            end
            rob_empty = 1'b1;
            if (!swap_valid) begin
                timeouts++;
                $display("Timeout: swap_valid never rose after the ROB drained (line %0d)", w);
                break;
            end
            assert (drained == drain_delay[w] + 1) else begin
                value_errors++;
                $display("ERROR draining cycles (line %0d): expected 0x%0h, got 0x%0h",
                         w, drain_delay[w] + 1, drained);
            end
            compare_flag("draining", 1'b0, draining);
            held = 0;
            while (held < ready_delay[w]) begin
                swap_ready = 1'b0;
                compare_flag("swap_valid", 1'b1, swap_valid);
                compare_core("swap_req.target", other_core, swap_req.target);
                compare_core("active_core", exp_core, active_core);
                held++;
                @(negedge clk);
                g++;
            end
            swap_ready = 1'b1;
            compare_flag("swap_valid", 1'b1, swap_valid);
            compare_core("swap_req.target", other_core, swap_req.target);
            @(negedge clk);
            g++;
            swap_ready = 1'b0;
            exp_core = other_core;
            compare_core("active_core", exp_core, active_core);
            compare_flag("swap_valid", 1'b0, swap_valid);
        end
    endtask

    initial begin
        int guard;
        ooo_events   = '0;
        ppl_events   = '0;
        rob_empty    = 1'b1;
        swap_ready   = 1'b0;
        value_errors = 0;
        data_errors  = 0;
        timeouts     = 0;
        load_scenarios();

        guard = 0;
        @(negedge clk);
        while (rst && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end

        if (rst) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end else if (num_lines == 0) begin
            data_errors++;
            $display("No scenario lines were read");
        end else begin
            compare_flag("swap_valid", 1'b0, swap_valid);
            compare_flag("draining", 1'b0, draining);
            compare_core("active_core", sched_pkg::CORE_OOO, active_core);
            compare_votes(-1, '0, votes);
            fork
                drive_windows();
                audit_votes();
                serve_swaps();
            join
        end

        $display("Errors: %0d value, %0d data, %0d timeout", value_errors, data_errors, timeouts);
        if (value_errors == 0 && data_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/sched_input.txt */
# ooo mult mem_op flush alu_op rob_full, ppl mult mem_op flush alu_op rob_full
# then drain_delay ready_delay migrate, all decimal, one window per line
10 10 5 40 20 10 10 5 40 20 0 0 0
5 30 8 40 10 20 10 2 30 10 3 2 1
10 10 5 20 42 10 10 5 30 0 0 0 0
10 10 5 20 43 10 10 5 30 0 1 4 1
5 30 5 40 10 20 10 5 40 10 0 0 0
2 40 12 5 60 30 5 1 50 3 80 3 1
4 35 10 8 50 25 10 2 40 5 0 0 1
25 10 2 40 5 4 35 10 8 50 0 0 0
1 20 6 10 30 9 10 3 20 30 2 5 1
0 0 0 0 0 0 0 0 0 0 0 0 0
10 10 5 40 43 10 10 5 30 0 0 0 0
10 10 9 40 64 10 10 3 40 0 0 0 0
0 64 64 0 0 64 0 0 64 0 0 20 1

/* sources.f */
design/sched_pkg.sv
design/perf_event_sampler.sv
design/migration_vote.sv
design/migration_controller.sv
design/hybrid_scheduler.sv
testbench/tb_clock_gen.sv
testbench/tb_hybrid_scheduler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f \
    --top-module tb_hybrid_scheduler -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_hybrid_scheduler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0
